//--- list.f
design/rv_pkg.sv
design/mem_port_if.sv
design/fetch_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mem_arbiter.sv
design/unified_memory.sv
design/rv_core.sv
verif/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/rv_core_tb.sv
module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int rows          = 8;
    localparam int prog_words    = 16;
    localparam int exit_timeout  = 2000;
    localparam int settle_cycles = 20;

    logic                      clk;
    logic                      reset;
    logic                      load_en;
    logic [rv_pkg::addr_w-1:0] load_addr;
    logic [rv_pkg::xlen-1:0]   load_data;
    logic                      exit;
    logic [31:0]               gp;

    // one short program per row, padded with ecall up to prog_words
    logic [31:0] prog [rows][prog_words];
    int          prog_len [rows];
    logic [31:0] exp_gp [rows];
    logic [31:0] ecall_w;
    logic [15:0] lfsr;

    rv_core dut_i (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .exit      (exit),
        .gp        (gp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // RV32I encoders, straight from the base ISA formats
    function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::opc_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::opc_store};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                rv_pkg::opc_branch};
    endfunction

    function automatic logic [31:0] u_type(input int rd, input int imm);
        return {imm[19:0], rd[4:0], rv_pkg::opc_lui};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::opc_jal};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_imm(output logic [11:0] v);
        v = '0;
        for (int i = 0; i < 12; i++) begin
            v    = {v[10:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic append_word(input int r, input logic [31:0] w);
        prog[r][prog_len[r]] = w;
        prog_len[r]          = prog_len[r] + 1;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_word(input string name, input logic [rv_pkg::xlen-1:0] expected,
                              input logic [rv_pkg::xlen-1:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected 0x%h, actual 0x%h", $time, name, expected,
                     actual);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // addi/xor chain on random immediates, result summed here
    task automatic build_random_row(input int r);
        logic [11:0] imm [4];
        logic [31:0] acc;
        for (int k = 0; k < 4; k++) begin
            take_imm(imm[k]);
        end
        append_word(r, i_type(rv_pkg::opc_op_imm, 0, 3, 0, int'(imm[0])));
        append_word(r, i_type(rv_pkg::opc_op_imm, 0, 4, 0, int'(imm[1])));
        append_word(r, i_type(rv_pkg::opc_op_imm, 0, 3, 3, int'(imm[2])));
        append_word(r, r_type(0, 0, 3, 3, 4));
        append_word(r, r_type(0, 4, 3, 3, 4));
        append_word(r, i_type(rv_pkg::opc_op_imm, 0, 3, 3, int'(imm[3])));
        append_word(r, ecall_w);
        acc = sext12(imm[0]) + sext12(imm[2]);
        acc = acc + sext12(imm[1]);
        acc = acc ^ sext12(imm[1]);
        exp_gp[r] = acc + sext12(imm[3]);
    endtask

    task automatic build_table();
        ecall_w = i_type(rv_pkg::opc_system, 0, 0, 0, 0);
        for (int r = 0; r < rows; r++) begin
            prog_len[r] = 0;
        end
        // alu ops and lui
        append_word(0, u_type(1, 'h12345));
        append_word(0, i_type(rv_pkg::opc_op_imm, 0, 2, 0, 'h678));
        append_word(0, r_type(0, 0, 3, 1, 2));
        append_word(0, i_type(rv_pkg::opc_op_imm, 0, 4, 0, -1));
        append_word(0, r_type(0, 4, 3, 3, 4));
        append_word(0, i_type(rv_pkg::opc_op_imm, 0, 5, 0, 'h0f0));
        append_word(0, r_type(0, 6, 3, 3, 5));
        append_word(0, r_type(32, 0, 3, 3, 2));
        append_word(0, u_type(6, 'hff00f));
        append_word(0, r_type(0, 7, 3, 3, 6));
        append_word(0, ecall_w);
        exp_gp[0] = 32'hed00a000;
        // forwarding from execute, memory and the register file
        append_word(1, i_type(rv_pkg::opc_op_imm, 0, 3, 0, 5));
        append_word(1, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 7));
        append_word(1, r_type(0, 0, 3, 3, 3));
        append_word(1, i_type(rv_pkg::opc_op_imm, 0, 7, 0, 1));
        append_word(1, r_type(0, 0, 3, 3, 3));
        append_word(1, i_type(rv_pkg::opc_op_imm, 0, 8, 0, 2));
        append_word(1, i_type(rv_pkg::opc_op_imm, 0, 9, 0, 3));
        append_word(1, r_type(32, 0, 3, 3, 8));
        append_word(1, r_type(32, 0, 3, 9, 3));
        append_word(1, ecall_w);
        exp_gp[1] = 32'hffffffd5;
        // store, then load-use twice
        append_word(2, i_type(rv_pkg::opc_op_imm, 0, 1, 0, 'h100));
        append_word(2, u_type(2, 'habcde));
        append_word(2, i_type(rv_pkg::opc_op_imm, 0, 2, 2, 'h123));
        append_word(2, i_type(rv_pkg::opc_op_imm, 0, 6, 0, 'h55));
        append_word(2, s_type(1, 2, 8));
        append_word(2, i_type(rv_pkg::opc_load, 2, 5, 1, 8));
        append_word(2, r_type(0, 0, 3, 5, 6));
        append_word(2, s_type(1, 3, 12));
        append_word(2, i_type(rv_pkg::opc_load, 2, 3, 1, 12));
        append_word(2, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 1));
        append_word(2, ecall_w);
        exp_gp[2] = 32'habcde179;
        // beq/bne both ways, poison after every taken one
        append_word(3, i_type(rv_pkg::opc_op_imm, 0, 3, 0, 10));
        append_word(3, i_type(rv_pkg::opc_op_imm, 0, 4, 0, 10));
        append_word(3, b_type(0, 3, 4, 8));
        append_word(3, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 100));
        append_word(3, b_type(1, 3, 4, 8));
        append_word(3, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 1));
        append_word(3, b_type(0, 3, 4, 8));
        append_word(3, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 2));
        append_word(3, b_type(1, 3, 4, 12));
        append_word(3, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 200));
        append_word(3, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 300));
        append_word(3, ecall_w);
        exp_gp[3] = 32'd13;
        // jal links pc+4 into x5, second jal drops its link on x0
        append_word(4, i_type(rv_pkg::opc_op_imm, 0, 3, 0, 1));
        append_word(4, j_type(5, 12));
        append_word(4, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 64));
        append_word(4, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 128));
        append_word(4, r_type(0, 0, 3, 3, 5));
        append_word(4, j_type(0, 8));
        append_word(4, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 256));
        append_word(4, r_type(0, 0, 3, 3, 0));
        append_word(4, ecall_w);
        exp_gp[4] = 32'd9;
        // writes to x0 go nowhere
        append_word(5, i_type(rv_pkg::opc_op_imm, 0, 0, 0, 123));
        append_word(5, i_type(rv_pkg::opc_op_imm, 0, 4, 0, 'h2aa));
        append_word(5, r_type(0, 0, 3, 0, 4));
        append_word(5, u_type(0, 'h11111));
        append_word(5, r_type(0, 0, 3, 3, 0));
        append_word(5, ecall_w);
        // poison right behind the ecall, already in flight when exit rises
        append_word(5, i_type(rv_pkg::opc_op_imm, 0, 3, 3, 1));
        exp_gp[5] = 32'h000002aa;
        build_random_row(6);
        build_random_row(7);
    endtask

    task automatic run_row(input int r);
        int cycles;
        reset = 1'b1;
        repeat (4) next_cycle();
        // program goes in while the core is still held in reset
        for (int i = 0; i < prog_words; i++) begin
            load_en   = 1'b1;
            load_addr = i[rv_pkg::addr_w-1:0];
            load_data = (i < prog_len[r]) ? prog[r][i] : ecall_w;
            next_cycle();
        end
        load_en = 1'b0;
        next_cycle();
        reset  = 1'b0;
        cycles = 0;
        while (exit !== 1'b1 && cycles < exit_timeout) begin
            next_cycle();
            cycles++;
        end
        if (exit !== 1'b1) begin
            $display("row %0d: exit never rose within %0d cycles", r, exit_timeout);
            $display("TEST FAIL");
            $fatal(1);
        end
        check_word($sformatf("gp (row %0d)", r), exp_gp[r], gp);
        // core has stopped, nothing may move
        repeat (settle_cycles) begin
            next_cycle();
            check_flag($sformatf("exit (row %0d, after ecall)", r), 1'b1, exit);
            check_word($sformatf("gp (row %0d, after ecall)", r), exp_gp[r], gp);
        end
    endtask

    initial begin
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr      = 16'd33361;
        build_table();
        for (int r = 0; r < rows; r++) begin
            run_row(r);
        end
        $display("TEST PASS");
        $finish;
    end
endmodule

//--- design/rv_core.sv
module rv_core (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load_en,
    input  logic [rv_pkg::addr_w-1:0]   load_addr,
    input  logic [rv_pkg::xlen-1:0]     load_data,
    output logic                        exit,
    output logic [31:0]                 gp
);
    logic                        if_valid;
    logic [31:0]                 if_pc;
    rv_pkg::inst_u               if_inst;
    logic                        stall_decode;
    logic                        stall_mem;
    logic                        redirect;
    logic [31:0]                 redirect_pc;
    rv_pkg::dec_ex_t             dec_ex;
    rv_pkg::ex_mem_t             ex_mem;
    rv_pkg::fwd_t                ex_fwd;
    rv_pkg::fwd_t                mem_fwd;
    logic                        wb_en;
    logic [4:0]                  wb_rd;
    logic [31:0]                 wb_data;
    logic                        mem_en;
    logic                        mem_we;
    logic [rv_pkg::addr_w-1:0]   mem_addr;
    logic [rv_pkg::xlen-1:0]     mem_wdata;
    logic [rv_pkg::xlen-1:0]     mem_rdata;

    mem_port_if inst_port ();
    mem_port_if data_port ();

    // fetch holds for either a load-use bubble or a waiting memory op
    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .port        (inst_port.requester),
        .stall       (stall_decode || stall_mem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halt        (exit),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_inst     (if_inst)
    );

    decode_stage u_decode (
        .clk          (clk),
        .reset        (reset),
        .if_valid     (if_valid),
        .if_pc        (if_pc),
        .if_inst      (if_inst),
        .flush        (redirect),
        .freeze       (stall_mem),
        .ex_fwd       (ex_fwd),
        .mem_fwd      (mem_fwd),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stall_decode (stall_decode),
        .dec_out      (dec_ex),
        .gp           (gp)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .dec_in      (dec_ex),
        .freeze      (stall_mem),
        .ex_out      (ex_mem),
        .ex_fwd      (ex_fwd),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage u_memory (
        .clk       (clk),
        .reset     (reset),
        .ex_in     (ex_mem),
        .port      (data_port.requester),
        .stall_mem (stall_mem),
        .mem_fwd   (mem_fwd),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .exit      (exit)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .inst_port (inst_port.arbiter),
        .data_port (data_port.arbiter),
        .en        (mem_en),
        .we        (mem_we),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .rdata     (mem_rdata)
    );

    unified_memory u_mem (
        .clk       (clk),
        .en        (mem_en),
        .we        (mem_we),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .rdata     (mem_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );
endmodule

//--- design/unified_memory.sv
module unified_memory (
    input  logic                        clk,
    input  logic                        en,
    input  logic                        we,
    input  logic [rv_pkg::addr_w-1:0]   addr,
    input  logic [rv_pkg::xlen-1:0]     wdata,
    output logic [rv_pkg::xlen-1:0]     rdata,
    input  logic                        load_en,
    input  logic [rv_pkg::addr_w-1:0]   load_addr,
    input  logic [rv_pkg::xlen-1:0]     load_data
);
    logic [rv_pkg::xlen-1:0] ram [rv_pkg::mem_words];

    // program load only happens with the core in reset
    always_ff @(posedge clk) begin
        if (load_en) begin
            ram[load_addr] <= load_data;
        end else if (en && we) begin
            ram[addr] <= wdata;
        end
        if (en) begin
            rdata <= ram[addr];
        end
    end
endmodule

//--- design/mem_arbiter.sv
module mem_arbiter (
    input  logic                        clk,
    input  logic                        reset,
    mem_port_if.arbiter                 inst_port,
    mem_port_if.arbiter                 data_port,
    output logic                        en,
    output logic                        we,
    output logic [rv_pkg::addr_w-1:0]   addr,
    output logic [rv_pkg::xlen-1:0]     wdata,
    input  logic [rv_pkg::xlen-1:0]     rdata
);
    // owner of the read that returns this cycle
    logic data_rd;
    logic inst_rd;

    // data side first, fetch only gets the idle cycles
    assign data_port.grant = !reset && data_port.req;
    assign inst_port.grant = !reset && inst_port.req && !data_port.req;

    assign en    = data_port.grant || inst_port.grant;
    assign we    = data_port.grant && data_port.we;
    assign addr  = data_port.grant ? data_port.addr[rv_pkg::addr_w+1:2] :
                                     inst_port.addr[rv_pkg::addr_w+1:2];
    assign wdata = data_port.wdata;

    assign data_port.rdata = data_rd ? rdata : '0;
    assign inst_port.rdata = inst_rd ? rdata : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            data_rd <= 1'b0;
            inst_rd <= 1'b0;
        end else begin
            data_rd <= data_port.grant && !data_port.we;
            inst_rd <= inst_port.grant && !inst_port.we;
        end
    end

    // a fetch that loses to the data side keeps asking for the same word
    assert property (@(posedge clk) disable iff (reset)
        inst_port.req && !inst_port.grant |=> inst_port.req && $stable(inst_port.addr))
        else $error("fetch request dropped or changed before its grant");
endmodule

//--- design/memory_stage.sv
module memory_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::ex_mem_t         ex_in,
    mem_port_if.requester           port,
    output logic                    stall_mem,
    output rv_pkg::fwd_t            mem_fwd,
    output logic                    wb_en,
    output logic [4:0]              wb_rd,
    output logic [31:0]             wb_data,
    output logic                    exit
);
    logic mem_op;
    // granted last cycle, so this is the finishing cycle
    logic pending;

    assign mem_op = ex_in.valid && (ex_in.is_load || ex_in.is_store) && !exit;

    assign port.req   = mem_op && !pending;
    assign port.we    = ex_in.is_store;
    assign port.addr  = ex_in.alu_result;
    assign port.wdata = ex_in.store_data;

    assign stall_mem = mem_op && !pending;

    always_comb begin
        case (ex_in.wb_sel)
            rv_pkg::wb_mem:      wb_data = port.rdata;
            rv_pkg::wb_pc_plus4: wb_data = ex_in.pc + 32'd4;
            default:             wb_data = ex_in.alu_result;
        endcase
    end

    // nothing behind the ecall may touch the registers
    assign wb_en = ex_in.valid && !exit && !stall_mem && ex_in.wb_sel != rv_pkg::wb_none;
    assign wb_rd = ex_in.rd;

    assign mem_fwd.valid       = ex_in.valid && !exit && ex_in.wb_sel != rv_pkg::wb_none;
    assign mem_fwd.can_forward = !stall_mem;
    assign mem_fwd.rd          = ex_in.rd;
    assign mem_fwd.data        = wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            exit    <= 1'b0;
        end else begin
            pending <= port.req && port.grant;
            if (ex_in.valid && ex_in.is_ecall) begin
                exit <= 1'b1;
            end
        end
    end
endmodule

//--- design/execute_stage.sv
module execute_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::dec_ex_t         dec_in,
    input  logic                    freeze,
    output rv_pkg::ex_mem_t         ex_out,
    output rv_pkg::fwd_t            ex_fwd,
    output logic                    redirect,
    output logic [31:0]             redirect_pc
);
    logic [31:0] alu_y;
    logic [31:0] link;
    logic        taken;

    always_comb begin
        case (dec_in.alu_op)
            rv_pkg::alu_sub:    alu_y = dec_in.a - dec_in.b;
            rv_pkg::alu_and:    alu_y = dec_in.a & dec_in.b;
            rv_pkg::alu_or:     alu_y = dec_in.a | dec_in.b;
            rv_pkg::alu_xor:    alu_y = dec_in.a ^ dec_in.b;
            rv_pkg::alu_pass_b: alu_y = dec_in.b;
            default:            alu_y = dec_in.a + dec_in.b;
        endcase
    end

    assign link  = dec_in.pc + 32'd4;
    assign taken = dec_in.is_jal ||
                   (dec_in.is_branch_eq && dec_in.a == dec_in.b) ||
                   (dec_in.is_branch_ne && dec_in.a != dec_in.b);

    // held back while frozen, fires once when the branch moves on
    assign redirect    = dec_in.valid && !freeze && taken;
    assign redirect_pc = dec_in.pc + dec_in.imm;

    // load data is not known yet, decode has to wait
    assign ex_fwd.valid       = dec_in.valid && dec_in.wb_sel != rv_pkg::wb_none;
    assign ex_fwd.can_forward = !dec_in.is_load;
    assign ex_fwd.rd          = dec_in.rd;
    assign ex_fwd.data        = dec_in.is_jal ? link : alu_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_out.valid <= 1'b0;
        end else if (!freeze) begin
            ex_out.valid      <= dec_in.valid;
            ex_out.pc         <= dec_in.pc;
            ex_out.alu_result <= alu_y;
            ex_out.store_data <= dec_in.rs2_val;
            ex_out.rd         <= dec_in.rd;
            ex_out.wb_sel     <= dec_in.wb_sel;
            ex_out.is_load    <= dec_in.is_load;
            ex_out.is_store   <= dec_in.is_store;
            ex_out.is_ecall   <= dec_in.is_ecall;
        end
    end

    // decode must hand over a bubble right after the flush
    assert property (@(posedge clk) disable iff (reset) redirect |=> !dec_in.valid)
        else $error("redirect not followed by a bubble from decode");
endmodule

//--- design/decode_stage.sv
module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    if_valid,
    input  logic [31:0]             if_pc,
    input  rv_pkg::inst_u           if_inst,
    input  logic                    flush,
    input  logic                    freeze,
    input  rv_pkg::fwd_t            ex_fwd,
    input  rv_pkg::fwd_t            mem_fwd,
    input  logic                    wb_en,
    input  logic [4:0]              wb_rd,
    input  logic [31:0]             wb_data,
    output logic                    stall_decode,
    output rv_pkg::dec_ex_t         dec_out,
    output logic [31:0]             gp
);
    logic [rv_pkg::xlen-1:0] regs [rv_pkg::reg_count];
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic                    use_rs1;
    logic                    use_rs2;
    logic [31:0]             rs1_val;
    logic [31:0]             rs2_val;
    logic [31:0]             imm_i;
    logic [31:0]             imm_s;
    logic [31:0]             imm_b;
    logic [31:0]             imm_u;
    logic [31:0]             imm_j;
    rv_pkg::dec_ex_t         dec;

    function automatic logic fwd_hit(rv_pkg::fwd_t f, logic [4:0] rs);
        return f.valid && f.rd == rs && rs != 5'd0;
    endfunction

    // execute beats memory, memory beats the register file
    function automatic logic [31:0] src_val(logic [4:0] rs, logic [31:0] rf_val,
                                            rv_pkg::fwd_t exf, rv_pkg::fwd_t memf);
        return (rs == 5'd0)      ? '0 :
               fwd_hit(exf, rs)  ? exf.data :
               fwd_hit(memf, rs) ? memf.data : rf_val;
    endfunction

    function automatic rv_pkg::alu_op_e alu_sel(logic [2:0] funct3, logic sub);
        case (funct3)
            3'b100:  return rv_pkg::alu_xor;
            3'b110:  return rv_pkg::alu_or;
            3'b111:  return rv_pkg::alu_and;
            default: return sub ? rv_pkg::alu_sub : rv_pkg::alu_add;
        endcase
    endfunction

    assign rs1 = if_inst.r_fmt.rs1;
    assign rs2 = if_inst.r_fmt.rs2;
    assign rs1_val = src_val(rs1, regs[rs1], ex_fwd, mem_fwd);
    assign rs2_val = src_val(rs2, regs[rs2], ex_fwd, mem_fwd);

    assign imm_i = {{20{if_inst.i_fmt.imm[11]}}, if_inst.i_fmt.imm};
    assign imm_s = {{20{if_inst.s_fmt.imm_hi[6]}}, if_inst.s_fmt.imm_hi, if_inst.s_fmt.imm_lo};
    assign imm_b = {{19{if_inst.b_fmt.imm12}}, if_inst.b_fmt.imm12, if_inst.b_fmt.imm11,
                    if_inst.b_fmt.imm10_5, if_inst.b_fmt.imm4_1, 1'b0};
    assign imm_u = {if_inst.u_fmt.imm, 12'b0};
    assign imm_j = {{11{if_inst.j_fmt.imm20}}, if_inst.j_fmt.imm20, if_inst.j_fmt.imm19_12,
                    if_inst.j_fmt.imm11, if_inst.j_fmt.imm10_1, 1'b0};

    // load in execute feeding this instruction, one bubble
    assign stall_decode = if_valid && !ex_fwd.can_forward &&
                          ((use_rs1 && fwd_hit(ex_fwd, rs1)) ||
                           (use_rs2 && fwd_hit(ex_fwd, rs2)));

    always_comb begin
        dec         = '0;
        dec.pc      = if_pc;
        dec.a       = rs1_val;
        dec.b       = rs2_val;
        dec.rs2_val = rs2_val;
        dec.imm     = imm_i;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (if_inst.r_fmt.opcode)
            rv_pkg::opc_op: begin
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                dec.alu_op = alu_sel(if_inst.r_fmt.funct3, if_inst.r_fmt.funct7[5]);
                dec.rd     = if_inst.r_fmt.rd;
                dec.wb_sel = rv_pkg::wb_alu;
            end
            rv_pkg::opc_op_imm: begin
                use_rs1    = 1'b1;
                dec.b      = imm_i;
                dec.alu_op = alu_sel(if_inst.i_fmt.funct3, 1'b0);
                dec.rd     = if_inst.i_fmt.rd;
                dec.wb_sel = rv_pkg::wb_alu;
            end
            rv_pkg::opc_lui: begin
                dec.b      = imm_u;
                dec.imm    = imm_u;
                dec.alu_op = rv_pkg::alu_pass_b;
                dec.rd     = if_inst.u_fmt.rd;
                dec.wb_sel = rv_pkg::wb_alu;
            end
            rv_pkg::opc_load: begin
                use_rs1     = 1'b1;
                dec.b       = imm_i;
                dec.rd      = if_inst.i_fmt.rd;
                dec.wb_sel  = rv_pkg::wb_mem;
                dec.is_load = 1'b1;
            end
            rv_pkg::opc_store: begin
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                dec.b        = imm_s;
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
            end
            rv_pkg::opc_branch: begin
                use_rs1          = 1'b1;
                use_rs2          = 1'b1;
                dec.imm          = imm_b;
                dec.is_branch_eq = if_inst.b_fmt.funct3 == 3'b000;
                dec.is_branch_ne = if_inst.b_fmt.funct3 == 3'b001;
            end
            rv_pkg::opc_jal: begin
                dec.imm    = imm_j;
                dec.rd     = if_inst.j_fmt.rd;
                dec.wb_sel = rv_pkg::wb_pc_plus4;
                dec.is_jal = 1'b1;
            end
            rv_pkg::opc_system: begin
                dec.is_ecall = 1'b1;
            end
            default: begin
                dec.wb_sel = rv_pkg::wb_none;
            end
        endcase
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            dec_out.valid <= 1'b0;
        end else if (!freeze) begin
            dec_out       <= dec;
            // a load-use hazard turns this slot into a bubble
            dec_out.valid <= if_valid && !stall_decode;
        end
    end

    assign gp = regs[3];

    // a load in execute never redirects, so the two stay apart
    assert property (@(posedge clk) disable iff (reset) flush |-> !stall_decode)
        else $error("load-use stall raised during a redirect flush");
endmodule

//--- design/fetch_unit.sv
module fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    mem_port_if.requester           port,
    input  logic                    stall,
    input  logic                    redirect,
    input  logic [31:0]             redirect_pc,
    input  logic                    halt,
    output logic                    if_valid,
    output logic [31:0]             if_pc,
    output rv_pkg::inst_u           if_inst
);
    logic [31:0] pc;
    logic        pend;
    logic [31:0] pend_pc;
    logic        hold_valid;
    logic [31:0] hold_pc;
    logic [31:0] hold_inst;

    // only ask when the returning word has somewhere to go
    assign port.req   = !halt && !(if_valid && stall);
    assign port.we    = 1'b0;
    assign port.addr  = pc;
    assign port.wdata = '0;

    assign if_valid = hold_valid || pend;
    assign if_pc    = hold_valid ? hold_pc : pend_pc;
    assign if_inst  = hold_valid ? hold_inst : port.rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= '0;
            pend       <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            // a redirect drops whatever is still on its way back
            pend       <= port.req && port.grant && !redirect;
            hold_valid <= if_valid && stall && !redirect;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (port.req && port.grant) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port.grant) begin
            pend_pc <= pc;
        end
        if (!hold_valid) begin
            hold_pc   <= pend_pc;
            hold_inst <= port.rdata;
        end
    end
endmodule

//--- design/mem_port_if.sv
interface mem_port_if;
    logic                    req;
    logic                    we;
    // byte address, word aligned
    logic [rv_pkg::xlen-1:0] addr;
    logic [rv_pkg::xlen-1:0] wdata;
    logic                    grant;
    // valid one cycle after a read grant
    logic [rv_pkg::xlen-1:0] rdata;

    modport requester (
        output req, we, addr, wdata,
        input  grant, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output grant, rdata
    );
endinterface

//--- design/rv_pkg.sv
package rv_pkg;

    localparam int xlen      = 32;
    localparam int mem_words = 1024;
    localparam int reg_count = 32;
    // word index into the unified memory
    localparam int addr_w    = $clog2(mem_words);

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, read through whichever format fits
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        alu_op_e         alu_op;
        logic [4:0]      rd;
        wb_sel_e         wb_sel;
        logic            is_load;
        logic            is_store;
        logic            is_branch_eq;
        logic            is_branch_ne;
        logic            is_jal;
        logic            is_ecall;
    } dec_ex_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
        wb_sel_e         wb_sel;
        logic            is_load;
        logic            is_store;
        logic            is_ecall;
    } ex_mem_t;

    // can_forward low means the value is not ready yet
    typedef struct packed {
        logic            valid;
        logic            can_forward;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } fwd_t;

endpackage
